// ==== bench/devil_stimulus.txt ====
# name ctrl delay acsnoop_reg base size snoop addr tamper kind crresp data end cont_final
# all numbers hex, kind is dummy, fuzz, delay or tamper
flt_op_miss 00014a01 0 00000007 00001000 00000100 3 00000001100 0 dummy 00 0 0 0
flt_addr_miss 00018a01 0 00000007 00001000 00000100 7 00000001100 0 dummy 00 0 0 0
flt_both_miss 0001ca01 0 00000007 00001000 00000100 7 00000000fff 0 dummy 00 0 0 0
osh_fuzz 0001ca01 0 00000007 00001000 00000100 7 abc000010ff 0 fuzz 05 0 1 0
osh_repeat 0001ca01 0 00000007 00001000 00000100 7 abc000010ff 0 dummy 00 0 1 0
osh_disable 00014a00 0 00000007 00000000 00000000 3 00000000000 0 dummy 00 0 0 0
osh_dly_crv 00012203 3 00000000 00000000 00000000 0 00000000000 0 delay 11 0 1 0
con_clear 00014a00 0 00000007 00000000 00000000 3 00000000000 0 dummy 00 0 0 0
con_dly_cdv 00021425 0 00000000 00000000 00000000 0 00000000000 0 delay 0a 0 0 0
con_dly_cdl 00023e27 2 00000000 00000000 00000000 0 00000000000 0 delay 1f 0 0 0
con_final 00020625 4 00000000 00000000 00000000 0 00000000000 0 delay 03 0 1 1
pdt_clear 00014a00 0 00000007 00000000 00000000 3 00000000000 0 dummy 00 0 0 0
pdt_tamper 00102a81 0 00000000 00000000 00000000 0 00000000000 0123456789abcdeffedcba9876543210 tamper 15 0123456789abcdeffedcba9876543210 1 0
pdt_off 00002a81 0 00000000 00000000 00000000 0 00000000000 0 dummy 00 0 1 0
func_rsvd 00000041 0 00000000 00000000 00000000 0 00000000000 0 dummy 00 0 1 0

// ==== filelist.f ====
+incdir+include
hdl/devil_pkg.sv
hdl/devil_decode.sv
hdl/devil_sequencer.sv
hdl/devil_reply.sv
hdl/devil_in_fpga.sv
bench/devil_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f --top-module devil_tb -o devil_sim
./obj_dir/devil_sim 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished cleanly"

// ==== bench/devil_tb.sv ====
`include "devil_defines.svh"

module devil_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_TESTS   = 32;
    localparam int STALL_ALLOW = 8;

    logic                        ace_aclk;
    logic                        ace_aresetn;
    logic [`DEVIL_REG_W-1:0]     control_reg;
    logic [`DEVIL_REG_W-1:0]     acsnoop_reg;
    logic [`DEVIL_REG_W-1:0]     base_addr_reg;
    logic [`DEVIL_REG_W-1:0]     addr_size_reg;
    logic [`DEVIL_DELAY_W-1:0]   delay_reg;
    logic [`DEVIL_ADDR_W-1:0]    acaddr_snapshot;
    logic [`DEVIL_SNOOP_W-1:0]   acsnoop_snapshot;
    logic                        trigger;
    logic                        crready;
    logic                        cdready;
    logic [`DEVIL_DATA_W-1:0]    tamper_data;
    logic                        crvalid;
    logic                        cdvalid;
    logic                        cdlast;
    logic [`DEVIL_CRRESP_W-1:0]  crresp;
    logic [`DEVIL_DATA_W-1:0]    rdata;
    logic                        reply;
    logic                        end_flag;
    logic                        busy;

    // one entry per stimulus line
    logic [8*16-1:0]             t_name   [MAX_TESTS];
    logic [31:0]                 t_ctrl   [MAX_TESTS];
    int                          t_delay  [MAX_TESTS];
    logic [31:0]                 t_opreg  [MAX_TESTS];
    logic [31:0]                 t_base   [MAX_TESTS];
    logic [31:0]                 t_size   [MAX_TESTS];
    logic [3:0]                  t_snoop  [MAX_TESTS];
    logic [43:0]                 t_addr   [MAX_TESTS];
    logic [127:0]                t_tamper [MAX_TESTS];
    logic [8*8-1:0]              t_kind   [MAX_TESTS];
    int                          t_crresp [MAX_TESTS];
    logic [127:0]                t_data   [MAX_TESTS];
    int                          t_end    [MAX_TESTS];
    int                          t_final  [MAX_TESTS];

    int                          num_tests = 0;
    int                          err_cnt = 0;
    int                          cycle_cnt = 0;
    int                          cycle_limit = 0;
    logic [31:0]                 rnd_state;
    logic [8*16-1:0]             cur_name;

    devil_in_fpga u_dut (
        .ace_aclk           (ace_aclk),
        .ace_aresetn        (ace_aresetn),
        .i_control_reg      (control_reg),
        .i_acsnoop_reg      (acsnoop_reg),
        .i_base_addr_reg    (base_addr_reg),
        .i_addr_size_reg    (addr_size_reg),
        .i_delay_reg        (delay_reg),
        .i_acaddr_snapshot  (acaddr_snapshot),
        .i_acsnoop_snapshot (acsnoop_snapshot),
        .i_trigger          (trigger),
        .i_crready          (crready),
        .i_cdready          (cdready),
        .i_tamper_data      (tamper_data),
        .o_crvalid          (crvalid),
        .o_cdvalid          (cdvalid),
        .o_cdlast           (cdlast),
        .o_crresp           (crresp),
        .o_rdata            (rdata),
        .o_reply            (reply),
        .o_end              (end_flag),
        .o_busy             (busy)
    );

    initial
    begin
        ace_aclk = 1'b0;
        forever #50 ace_aclk = ~ace_aclk;
    end

    // run limit, set once the stimulus is loaded
    always @(posedge ace_aclk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
        begin
            $display("Some tests failed");
            $fatal(1, "timeout, the DUT did not finish within %0d cycles", cycle_limit);
        end
    end

    ////////////////////
    // helpers
    ////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 2^(d-1) base units, none for d = 0
    function automatic int delay_for(input int d);
        if (d == 0)
            return 0;
        return (1 << (d - 1)) * `DEVIL_DELAY_BASE;
    endfunction

    task automatic check_int(input string what, input int exp, input int act);
        assert (act == exp)
        else
        begin
            err_cnt++;
            $display("Error: test %0s, %0s: expected %0d, actual %0d", cur_name, what, exp, act);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_wide(input string what, input logic [127:0] exp,
                              input logic [127:0] act);
        assert (act === exp)
        else
        begin
            err_cnt++;
            $display("Error: test %0s, %0s: expected %0h, actual %0h", cur_name, what, exp, act);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic stop_with_problem(input string msg);
        err_cnt++;
        $display("test %0s: %0s", cur_name, msg);
        $display("Some tests failed");
        $fatal(1, "stopping on a testbench problem");
    endtask

    task automatic load_stimulus();
        int    fd;
        int    got;
        string line;
        fd = $fopen("bench/devil_stimulus.txt", "r");
        if (fd == 0)
            stop_with_problem("cannot open the stimulus file");
        while (!$feof(fd) && num_tests < MAX_TESTS)
        begin
            got = $fgets(line, fd);
            if (got > 0 && line.getc(0) != "#")
            begin
                got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %s %h %h %h %h",
                    t_name[num_tests], t_ctrl[num_tests], t_delay[num_tests],
                    t_opreg[num_tests], t_base[num_tests], t_size[num_tests],
                    t_snoop[num_tests], t_addr[num_tests], t_tamper[num_tests],
                    t_kind[num_tests], t_crresp[num_tests], t_data[num_tests],
                    t_end[num_tests], t_final[num_tests]);
                if (got == 14)
                    num_tests++;
            end
        end
        $fclose(fd);
        if (num_tests == 0)
            stop_with_problem("the stimulus file holds no tests");
        // reset plus per-test allowance
        cycle_limit = 10;
        for (int i = 0; i < num_tests; i++)
            cycle_limit += 30 + delay_for(t_delay[i]) + STALL_ALLOW;
    endtask

    ////////////////////
    // one snoop per test
    ////////////////////
    task automatic run_test(input int i);
        int         stall_cr;
        int         stall_cd;
        int         ready_cyc;
        int         dly;
        int         cyc;
        int         since_cr;
        int         cr_cnt;
        int         cdv_cnt;
        int         cdl_cnt;
        int         cr_first;
        int         cdv_first;
        int         cdl_first;
        logic       done;
        logic [3:0] test_sel;
        logic [4:0] seen_crresp;
        logic [127:0] seen_data;
        cur_name = t_name[i];
        rnd_state = xorshift32(rnd_state);
        stall_cr = int'(rnd_state % 4);
        rnd_state = xorshift32(rnd_state);
        stall_cd = int'(rnd_state % 4);
        // cycles counted from FILTER, the chosen path waits from cycle 2 on
        ready_cyc = 2 + stall_cr;
        dly = delay_for(t_delay[i]);
        test_sel = t_ctrl[i][`CTRL_TEST_LSB +: `CTRL_TEST_W];
        cr_cnt = 0;
        cdv_cnt = 0;
        cdl_cnt = 0;
        cr_first = -1;
        cdv_first = -1;
        cdl_first = -1;
        since_cr = -1;
        seen_crresp = '0;
        seen_data = '0;

        // program registers while idle
        control_reg      = t_ctrl[i];
        acsnoop_reg      = t_opreg[i];
        base_addr_reg    = t_base[i];
        addr_size_reg    = t_size[i];
        delay_reg        = 4'(t_delay[i]);
        acsnoop_snapshot = t_snoop[i];
        acaddr_snapshot  = t_addr[i];
        tamper_data      = t_tamper[i];
        crready          = 1'b0;
        cdready          = 1'b0;
        @(negedge ace_aclk);
        @(negedge ace_aclk);
        check_int("idle strobes, reply and busy", 0,
                  int'({crvalid, cdvalid, cdlast, reply, busy}));
        if (!t_ctrl[i][`CTRL_EN])
            check_int("o_end while idle and disabled", 0, int'(end_flag));

        trigger = 1'b1;
        @(negedge ace_aclk);
        trigger = 1'b0;
        // this negedge falls in FILTER
        if (t_final[i] != 0)
            control_reg[`CTRL_CON_EN] = 1'b0;

        cyc = 0;
        done = 1'b0;
        while (!done)
        begin
            if (crvalid)
            begin
                if (cr_first < 0)
                    cr_first = cyc;
                cr_cnt++;
                seen_crresp = crresp;
                seen_data = rdata;
            end
            if (cdvalid)
            begin
                if (cdv_first < 0)
                    cdv_first = cyc;
                cdv_cnt++;
            end
            if (cdlast)
            begin
                if (cdl_first < 0)
                    cdl_first = cyc;
                cdl_cnt++;
            end
            if (since_cr >= 0)
                since_cr++;
            else if (crvalid)
                since_cr = 0;
            if (reply)
                done = 1'b1;
            else
            begin
                check_int("busy while handling the snoop", 1, int'(busy));
                crready = (cyc >= ready_cyc);
                cdready = (since_cr >= stall_cd);
                cyc++;
                @(negedge ace_aclk);
            end
        end

        check_int("crvalid at the reply pulse", 0, int'(crvalid));
        check_int("o_end", t_end[i], int'(end_flag));
        check_int("crresp", t_crresp[i], int'(seen_crresp));
        check_wide("response data", t_data[i], seen_data);

        if (t_kind[i] == 64'("dummy"))
        begin
            check_int("crvalid cycles", 1, cr_cnt);
            check_int("cdvalid cycles", 0, cdv_cnt);
            check_int("cdlast cycles", 0, cdl_cnt);
        end
        else if (t_kind[i] == 64'("fuzz"))
        begin
            // response one cycle after crready is seen, strobes the cycle after
            check_int("crvalid cycles", 1, cr_cnt);
            check_int("cdvalid cycles", 1, cdv_cnt);
            check_int("cdlast cycles", 1, cdl_cnt);
            check_int("crvalid rise", ready_cyc + 2, cr_first);
            check_int("cdvalid rise", ready_cyc + 2, cdv_first);
            check_int("cdlast rise", ready_cyc + 2, cdl_first);
        end
        else if (t_kind[i] == 64'("delay"))
        begin
            case (test_sel)
                4'd1:
                begin
                    check_int("crvalid cycles", 1, cr_cnt);
                    check_int("cdvalid cycles", 0, cdv_cnt);
                    check_int("cdlast cycles", 0, cdl_cnt);
                    check_int("crvalid delayed rise", ready_cyc + 3 + dly, cr_first);
                end
                4'd2:
                begin
                    check_int("crvalid cycles", dly + 2, cr_cnt);
                    check_int("cdlast cycles", dly + 2, cdl_cnt);
                    check_int("cdvalid cycles", 1, cdv_cnt);
                    check_int("crvalid rise", ready_cyc + 2, cr_first);
                    check_int("cdlast rise", ready_cyc + 2, cdl_first);
                    check_int("cdvalid delay gap", dly + 1, cdv_first - cr_first);
                end
                4'd3:
                begin
                    check_int("crvalid cycles", dly + 2, cr_cnt);
                    check_int("cdvalid cycles", dly + 2, cdv_cnt);
                    check_int("cdlast cycles", 1, cdl_cnt);
                    check_int("crvalid rise", ready_cyc + 2, cr_first);
                    check_int("cdvalid rise", ready_cyc + 2, cdv_first);
                    check_int("cdlast delay gap", dly + 1, cdl_first - cr_first);
                end
                default:
                    stop_with_problem("a delay test line selects no delay test");
            endcase
        end
        else if (t_kind[i] == 64'("tamper"))
        begin
            // held from crready until one cycle past cdready
            check_int("crvalid cycles", stall_cd + 2, cr_cnt);
            check_int("cdvalid cycles", stall_cd + 2, cdv_cnt);
            check_int("cdlast cycles", stall_cd + 2, cdl_cnt);
            check_int("crvalid rise", ready_cyc + 1, cr_first);
            check_int("cdvalid rise", ready_cyc + 1, cdv_first);
            check_int("cdlast rise", ready_cyc + 1, cdl_first);
        end
        else
            stop_with_problem("unknown expected kind in the stimulus file");

        crready = 1'b0;
        cdready = 1'b0;
        @(negedge ace_aclk);
        check_int("reply pulse length", 0, int'(reply));
        check_int("busy after completion", 0, int'(busy));
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial
    begin
        ace_aresetn      = 1'b0;
        control_reg      = '0;
        acsnoop_reg      = '0;
        base_addr_reg    = '0;
        addr_size_reg    = '0;
        delay_reg        = '0;
        acaddr_snapshot  = '0;
        acsnoop_snapshot = '0;
        trigger          = 1'b0;
        crready          = 1'b0;
        cdready          = 1'b0;
        tamper_data      = '0;
        rnd_state        = 32'd76340;
        cur_name         = 128'("reset");
        load_stimulus();

        repeat (5) @(posedge ace_aclk);
        @(negedge ace_aclk);
        ace_aresetn = 1'b1;
        @(negedge ace_aclk);
        check_int("outputs after reset", 0,
                  int'({crvalid, cdvalid, cdlast, reply, end_flag, busy}));

        for (int i = 0; i < num_tests; i++)
            run_test(i);

        if (err_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== hdl/devil_in_fpga.sv ====
`include "devil_defines.svh"

module devil_in_fpga (
    input  logic                        ace_aclk,
    input  logic                        ace_aresetn,
    input  logic [`DEVIL_REG_W-1:0]     i_control_reg,
    input  logic [`DEVIL_REG_W-1:0]     i_acsnoop_reg,
    input  logic [`DEVIL_REG_W-1:0]     i_base_addr_reg,
    input  logic [`DEVIL_REG_W-1:0]     i_addr_size_reg,
    input  logic [`DEVIL_DELAY_W-1:0]   i_delay_reg,
    input  logic [`DEVIL_ADDR_W-1:0]    i_acaddr_snapshot,
    input  logic [`DEVIL_SNOOP_W-1:0]   i_acsnoop_snapshot,
    input  logic                        i_trigger,
    input  logic                        i_crready,
    input  logic                        i_cdready,
    input  logic [`DEVIL_DATA_W-1:0]    i_tamper_data,
    output logic                        o_crvalid,
    output logic                        o_cdvalid,
    output logic                        o_cdlast,
    output logic [`DEVIL_CRRESP_W-1:0]  o_crresp,
    output logic [`DEVIL_DATA_W-1:0]    o_rdata,
    output logic                        o_reply,
    output logic                        o_end,
    output logic                        o_busy
);
    import devil_pkg::*;

    logic                        en;
    logic                        osh_en;
    logic                        con_en;
    logic                        pdt_en;
    logic                        filter_pass;
    devil_func_e                 func;
    devil_test_e                 test;
    logic [`DEVIL_CRRESP_W-1:0]  ctrl_crresp;
    reply_cmd_e                  cmd;
    logic [2:0]                  mask;

    devil_decode u_decode (
        .ace_aclk           (ace_aclk),
        .ace_aresetn        (ace_aresetn),
        .i_control_reg      (i_control_reg),
        .i_acsnoop_reg      (i_acsnoop_reg),
        .i_base_addr_reg    (i_base_addr_reg),
        .i_addr_size_reg    (i_addr_size_reg),
        .i_acaddr_snapshot  (i_acaddr_snapshot),
        .i_acsnoop_snapshot (i_acsnoop_snapshot),
        .o_en               (en),
        .o_osh_en           (osh_en),
        .o_con_en           (con_en),
        .o_pdt_en           (pdt_en),
        .o_filter_pass      (filter_pass),
        .o_func             (func),
        .o_test             (test),
        .o_crresp           (ctrl_crresp)
    );

    devil_sequencer u_sequencer (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_trigger     (i_trigger),
        .i_crready     (i_crready),
        .i_cdready     (i_cdready),
        .i_en          (en),
        .i_osh_en      (osh_en),
        .i_con_en      (con_en),
        .i_pdt_en      (pdt_en),
        .i_filter_pass (filter_pass),
        .i_func        (func),
        .i_test        (test),
        .i_delay_reg   (i_delay_reg),
        .o_cmd         (cmd),
        .o_mask        (mask),
        .o_busy        (o_busy)
    );

    devil_reply u_reply (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_cmd         (cmd),
        .i_mask        (mask),
        .i_en          (en),
        .i_busy        (o_busy),
        .i_crresp      (ctrl_crresp),
        .i_tamper_data (i_tamper_data),
        .o_crvalid     (o_crvalid),
        .o_cdvalid     (o_cdvalid),
        .o_cdlast      (o_cdlast),
        .o_reply       (o_reply),
        .o_end         (o_end),
        .o_crresp      (o_crresp),
        .o_rdata       (o_rdata)
    );

endmodule

// ==== hdl/devil_reply.sv ====
`include "devil_defines.svh"

module devil_reply (
    input  logic                        ace_aclk,
    input  logic                        ace_aresetn,
    input  devil_pkg::reply_cmd_e       i_cmd,
    input  logic [2:0]                  i_mask,
    input  logic                        i_en,
    input  logic                        i_busy,
    input  logic [`DEVIL_CRRESP_W-1:0]  i_crresp,
    input  logic [`DEVIL_DATA_W-1:0]    i_tamper_data,
    output logic                        o_crvalid,
    output logic                        o_cdvalid,
    output logic                        o_cdlast,
    output logic                        o_reply,
    output logic                        o_end,
    output logic [`DEVIL_CRRESP_W-1:0]  o_crresp,
    output logic [`DEVIL_DATA_W-1:0]    o_rdata
);
    import devil_pkg::*;

    ////////////////////
    // strobes and completion
    ////////////////////
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_crvalid <= 1'b0;
            o_cdvalid <= 1'b0;
            o_cdlast  <= 1'b0;
            o_reply   <= 1'b0;
            o_end     <= 1'b0;
        end
        else
        begin
            o_reply <= 1'b0;
            case (i_cmd)
                CMD_DUMMY:
                    o_crvalid <= 1'b1;
                CMD_TAMPER:
                begin
                    o_crvalid <= 1'b1;
                    o_cdvalid <= 1'b1;
                    o_cdlast  <= 1'b1;
                end
                // delayed strobes add to the ones already up
                CMD_ASSERT_MASK:
                begin
                    o_crvalid <= o_crvalid | i_mask[0];
                    o_cdvalid <= o_cdvalid | i_mask[1];
                    o_cdlast  <= o_cdlast | i_mask[2];
                end
                CMD_FINISH_REPLY, CMD_FINISH_OP:
                begin
                    o_crvalid <= 1'b0;
                    o_cdvalid <= 1'b0;
                    o_cdlast  <= 1'b0;
                    o_reply   <= 1'b1;
                end
                default:
                begin
                end
            endcase
            if (i_cmd == CMD_FINISH_OP)
                o_end <= 1'b1;
            else if (!i_busy && !i_en)
                o_end <= 1'b0;
        end
    end

    // response payload
    always_ff @(posedge ace_aclk)
    begin
        case (i_cmd)
            CMD_DUMMY:
            begin
                o_crresp <= '0;
                o_rdata  <= '0;
            end
            CMD_TAMPER:
            begin
                o_crresp <= i_crresp;
                o_rdata  <= i_tamper_data;
            end
            CMD_ASSERT_MASK:
            begin
                o_crresp <= i_crresp;
                o_rdata  <= '0;
            end
            default:
            begin
            end
        endcase
    end

    a_reply_not_with_crvalid: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        !(o_reply && o_crvalid));

    a_no_cdlast_after_end: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        $rose(o_cdlast) |-> !(o_end && !i_busy));

endmodule

// ==== hdl/devil_sequencer.sv ====
`include "devil_defines.svh"

module devil_sequencer (
    input  logic                        ace_aclk,
    input  logic                        ace_aresetn,
    input  logic                        i_trigger,
    input  logic                        i_crready,
    input  logic                        i_cdready,
    input  logic                        i_en,
    input  logic                        i_osh_en,
    input  logic                        i_con_en,
    input  logic                        i_pdt_en,
    input  logic                        i_filter_pass,
    input  devil_pkg::devil_func_e      i_func,
    input  devil_pkg::devil_test_e      i_test,
    input  logic [`DEVIL_DELAY_W-1:0]   i_delay_reg,
    output devil_pkg::reply_cmd_e       o_cmd,
    output logic [2:0]                  o_mask,
    output logic                        o_busy
);
    import devil_pkg::*;

    devil_state_e             state;
    devil_state_e             state_nxt;
    devil_state_e             ret_state;
    devil_state_e             ret_nxt;
    logic                     osh_done;
    logic [`DEVIL_REG_W-1:0]  delay_cnt;
    logic [`DEVIL_REG_W-1:0]  delay_cycles;
    logic                     delay_hit;

    // zero for d = 0, else base << (d-1)
    assign delay_cycles = (i_delay_reg == '0) ? '0
                        : (`DEVIL_REG_W'(`DEVIL_DELAY_BASE) << (i_delay_reg - 1'b1));
    assign delay_hit    = (delay_cnt == delay_cycles);
    assign o_busy       = (state != ST_IDLE);

    ////////////////////
    // next state and reply command
    ////////////////////
    // mask bits: 0 crvalid, 1 cdvalid, 2 cdlast
    always_comb
    begin
        state_nxt = state;
        ret_nxt   = ret_state;
        o_cmd     = CMD_NONE;
        o_mask    = 3'b000;
        case (state)
            ST_IDLE:
            begin
                if (i_trigger)
                    state_nxt = ST_FILTER;
            end
            ST_FILTER:
                state_nxt = i_filter_pass ? ST_FUNCTION : ST_DUMMY;
            ST_FUNCTION:
            begin
                case (i_func)
                    FUNC_OSH: state_nxt = i_osh_en ? ST_ONE_SHOT : ST_DUMMY;
                    // continuous enable only selects the final reply
                    FUNC_CON: state_nxt = ST_CONTINUOUS;
                    FUNC_PDT: state_nxt = i_pdt_en ? ST_PASSIVE_TAMP : ST_DUMMY;
                    default:  state_nxt = ST_DUMMY;
                endcase
            end
            ST_ONE_SHOT:
            begin
                if (i_crready)
                begin
                    // already fired, answer plainly until disabled
                    if (osh_done)
                        state_nxt = ST_DUMMY;
                    else
                    begin
                        state_nxt = ST_RESPONSE;
                        ret_nxt   = ST_END_OP;
                    end
                end
            end
            ST_CONTINUOUS:
            begin
                if (i_crready)
                begin
                    state_nxt = ST_RESPONSE;
                    ret_nxt   = i_con_en ? ST_END_REPLY : ST_END_OP;
                end
            end
            ST_PASSIVE_TAMP:
            begin
                if (i_crready)
                begin
                    o_cmd = CMD_TAMPER;
                    // data must hold until cdready
                    if (i_cdready)
                        state_nxt = ST_END_OP;
                end
            end
            ST_RESPONSE:
            begin
                case (i_test)
                    TEST_FUZZING:
                    begin
                        o_cmd     = CMD_ASSERT_MASK;
                        o_mask    = 3'b111;
                        state_nxt = ret_state;
                    end
                    TEST_DELAY_CRVALID:
                        state_nxt = ST_DELAY;
                    TEST_DELAY_CDVALID:
                    begin
                        o_cmd     = CMD_ASSERT_MASK;
                        o_mask    = 3'b101;
                        state_nxt = ST_DELAY;
                    end
                    TEST_DELAY_CDLAST:
                    begin
                        o_cmd     = CMD_ASSERT_MASK;
                        o_mask    = 3'b011;
                        state_nxt = ST_DELAY;
                    end
                    default:
                        state_nxt = ret_state;
                endcase
            end
            ST_DELAY:
            begin
                if (delay_hit)
                begin
                    o_cmd     = CMD_ASSERT_MASK;
                    state_nxt = ret_state;
                    case (i_test)
                        TEST_DELAY_CRVALID: o_mask = 3'b001;
                        TEST_DELAY_CDVALID: o_mask = 3'b010;
                        TEST_DELAY_CDLAST:  o_mask = 3'b100;
                        default:            o_mask = 3'b000;
                    endcase
                end
            end
            ST_DUMMY:
            begin
                if (i_crready)
                begin
                    o_cmd     = CMD_DUMMY;
                    state_nxt = ST_END_REPLY;
                end
            end
            ST_END_OP:
            begin
                o_cmd     = CMD_FINISH_OP;
                state_nxt = ST_IDLE;
            end
            ST_END_REPLY:
            begin
                o_cmd     = CMD_FINISH_REPLY;
                state_nxt = ST_IDLE;
            end
            default:
                state_nxt = ST_IDLE;
        endcase
    end

    ////////////////////
    // state, one-shot flag, delay counter
    ////////////////////
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state     <= ST_IDLE;
            ret_state <= ST_END_REPLY;
            osh_done  <= 1'b0;
            delay_cnt <= '0;
        end
        else
        begin
            state     <= state_nxt;
            ret_state <= ret_nxt;
            if (state == ST_RESPONSE && i_func == FUNC_OSH)
                osh_done <= 1'b1;
            else if (state == ST_IDLE && !i_en)
                osh_done <= 1'b0;
            if (state == ST_DELAY && !delay_hit)
                delay_cnt <= delay_cnt + 1'b1;
            else
                delay_cnt <= '0;
        end
    end

    a_filter_one_cycle: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (state == ST_FILTER) |=> (state == ST_FUNCTION || state == ST_DUMMY));

    a_function_one_cycle: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (state == ST_FUNCTION) |=> (state != ST_FUNCTION));

endmodule

// ==== hdl/devil_decode.sv ====
`include "devil_defines.svh"

module devil_decode (
    input  logic                        ace_aclk,
    input  logic                        ace_aresetn,
    input  logic [`DEVIL_REG_W-1:0]     i_control_reg,
    input  logic [`DEVIL_REG_W-1:0]     i_acsnoop_reg,
    input  logic [`DEVIL_REG_W-1:0]     i_base_addr_reg,
    input  logic [`DEVIL_REG_W-1:0]     i_addr_size_reg,
    input  logic [`DEVIL_ADDR_W-1:0]    i_acaddr_snapshot,
    input  logic [`DEVIL_SNOOP_W-1:0]   i_acsnoop_snapshot,
    output logic                        o_en,
    output logic                        o_osh_en,
    output logic                        o_con_en,
    output logic                        o_pdt_en,
    output logic                        o_filter_pass,
    output devil_pkg::devil_func_e      o_func,
    output devil_pkg::devil_test_e      o_test,
    output logic [`DEVIL_CRRESP_W-1:0]  o_crresp
);
    import devil_pkg::*;

    logic [`CTRL_FUNC_W-1:0]  func_raw;
    logic                     ac_flt;
    logic                     addr_flt;
    logic                     ac_match;
    logic                     addr_match;
    logic [`DEVIL_REG_W-1:0]  snap_addr_lo;
    logic [`DEVIL_REG_W:0]    window_end;

    ////////////////////
    // control register fields
    ////////////////////
    assign o_en     = i_control_reg[`CTRL_EN];
    assign o_osh_en = i_control_reg[`CTRL_OSH_EN];
    assign o_con_en = i_control_reg[`CTRL_CON_EN];
    assign o_pdt_en = i_control_reg[`CTRL_PDT_EN];
    assign o_crresp = i_control_reg[`CTRL_CRRESP_LSB +: `DEVIL_CRRESP_W];
    assign o_test   = devil_test_e'(i_control_reg[`CTRL_TEST_LSB +: `CTRL_TEST_W]);
    assign func_raw = i_control_reg[`CTRL_FUNC_LSB +: `CTRL_FUNC_W];
    assign ac_flt   = i_control_reg[`CTRL_AC_FLT];
    assign addr_flt = i_control_reg[`CTRL_ADDR_FLT];

    // leak and active tamper codes are not supported here
    always_comb
    begin
        case (func_raw)
            4'd0:    o_func = FUNC_OSH;
            4'd1:    o_func = FUNC_CON;
            4'd4:    o_func = FUNC_PDT;
            default: o_func = FUNC_UNKNOWN;
        endcase
    end

    ////////////////////
    // snoop filters
    ////////////////////
    // window compared on the low 32 address bits only
    assign snap_addr_lo  = i_acaddr_snapshot[`DEVIL_REG_W-1:0];
    assign window_end    = {1'b0, i_base_addr_reg} + {1'b0, i_addr_size_reg};
    assign ac_match      = (i_acsnoop_snapshot == i_acsnoop_reg[`DEVIL_SNOOP_W-1:0]);
    assign addr_match    = (snap_addr_lo >= i_base_addr_reg)
                        && ({1'b0, snap_addr_lo} < window_end);
    assign o_filter_pass = (!ac_flt || ac_match) && (!addr_flt || addr_match);

    // an enabled address window must fit below 4 GiB
    a_window_fits: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (o_en && addr_flt) |-> !window_end[`DEVIL_REG_W] || (window_end[`DEVIL_REG_W-1:0] == '0));

endmodule

// ==== hdl/devil_pkg.sv ====
package devil_pkg;

    ////////////////////
    // snoop handling FSM
    ////////////////////
    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_FILTER,
        ST_FUNCTION,
        ST_ONE_SHOT,
        ST_CONTINUOUS,
        ST_PASSIVE_TAMP,
        ST_RESPONSE,
        ST_DELAY,
        ST_DUMMY,
        ST_END_OP,
        ST_END_REPLY
    } devil_state_e;

    // codes 2 and 3 are reserved, anything unlisted decodes to FUNC_UNKNOWN
    typedef enum logic [3:0]
    {
        FUNC_OSH     = 4'd0,
        FUNC_CON     = 4'd1,
        FUNC_PDT     = 4'd4,
        FUNC_UNKNOWN = 4'd15
    } devil_func_e;

    typedef enum logic [3:0]
    {
        TEST_FUZZING       = 4'd0,
        TEST_DELAY_CRVALID = 4'd1,
        TEST_DELAY_CDVALID = 4'd2,
        TEST_DELAY_CDLAST  = 4'd3
    } devil_test_e;

    ////////////////////
    // sequencer to reply commands
    ////////////////////
    typedef enum logic [2:0]
    {
        CMD_NONE,
        CMD_DUMMY,
        CMD_TAMPER,
        CMD_ASSERT_MASK,
        CMD_FINISH_REPLY,
        CMD_FINISH_OP
    } reply_cmd_e;

endpackage

// ==== include/devil_defines.svh ====
`ifndef DEVIL_DEFINES_SVH
`define DEVIL_DEFINES_SVH

////////////////////
// bus and register widths
////////////////////
`define DEVIL_REG_W       32
`define DEVIL_ADDR_W      44
`define DEVIL_DATA_W      128
`define DEVIL_CRRESP_W    5
`define DEVIL_SNOOP_W     4
`define DEVIL_DELAY_W     4

// cycles per delay unit, scaled by 2^(d-1)
`define DEVIL_DELAY_BASE  1

////////////////////
// control register fields
////////////////////
`define CTRL_EN           0
`define CTRL_TEST_LSB     1
`define CTRL_TEST_W       4
`define CTRL_FUNC_LSB     5
`define CTRL_FUNC_W       4
`define CTRL_CRRESP_LSB   9
`define CTRL_AC_FLT       14
`define CTRL_ADDR_FLT     15
`define CTRL_OSH_EN       16
`define CTRL_CON_EN       17
`define CTRL_PDT_EN       20

`endif
